/* Makefile */
VERILATOR ?= verilator
TOP       ?= vWriteTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= *** PASSED ***

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* hw/extWriteEngine.sv */
`timescale 1ns/100ps

module extWriteEngine
(
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 run,
   input  versatPkg::extConfigT cfg,
   output versatPkg::memReadT   memRead,
   input  versatPkg::dataT      readData,
   input  logic                 busReady,
   output versatPkg::busReqT    busReq,
   output logic                 done
);

   versatPkg::extStateT state;
   versatPkg::ioSizeT   wordCnt;
   versatPkg::memAddrT  intPtr;
   versatPkg::ioAddrT   extPtr;
   logic                reqValid;
   versatPkg::ioAddrT   reqAddr;
   versatPkg::dataT     reqData;
   logic                start;
   logic                xfer;
   logic                lastWord;

   assign start    = run && state == versatPkg::EXT_IDLE && cfg.size != '0;
   assign xfer     = state == versatPkg::EXT_WAIT && reqValid && busReady;
   assign lastWord = wordCnt == versatPkg::ioSizeT'(1);

   // first read goes out with run and later ones right after each transfer
   always_comb
   begin
      memRead.en = start || (xfer && !lastWord);
      if (state == versatPkg::EXT_IDLE)
         memRead.addr = cfg.intAddr;
      else
         memRead.addr = intPtr + 1'b1;
   end

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         state    <= versatPkg::EXT_IDLE;
         wordCnt  <= '0;
         intPtr   <= '0;
         extPtr   <= '0;
         reqValid <= 1'b0;
         done     <= 1'b1;
      end
      else
      begin
         case (state)
            versatPkg::EXT_IDLE:
               if (start)
               begin
                  state   <= versatPkg::EXT_READ;
                  wordCnt <= cfg.size;
                  intPtr  <= cfg.intAddr;
                  extPtr  <= cfg.extAddr;
                  done    <= 1'b0;
               end
            versatPkg::EXT_READ:
            begin
               state    <= versatPkg::EXT_WAIT;
               reqValid <= 1'b1;
            end
            versatPkg::EXT_WAIT:
               if (xfer)
               begin
                  reqValid <= 1'b0;
                  wordCnt  <= wordCnt - 1'b1;
                  intPtr   <= intPtr + 1'b1;
                  extPtr   <= extPtr + versatPkg::BYTES_PER_WORD;
                  if (lastWord)
                  begin
                     state <= versatPkg::EXT_IDLE;
                     done  <= 1'b1;
                  end
                  else
                     state <= versatPkg::EXT_READ;
               end
            default:
               state <= versatPkg::EXT_IDLE;
         endcase
      end
   end

   // memory output is valid in EXT_READ and is captured for the bus
   always_ff @(posedge clk)
   begin
      if (state == versatPkg::EXT_READ)
      begin
         reqAddr <= extPtr;
         reqData <= readData;
      end
   end

   always_comb
   begin
      busReq.valid = reqValid;
      busReq.addr  = reqAddr;
      busReq.wdata = reqData;
   end

   holdUnderStall: assert property (@(posedge clk) disable iff (!rstN)
      busReq.valid && !busReady |=>
         busReq.valid && $stable(busReq.addr) && $stable(busReq.wdata));

endmodule

/* hw/flowAddrGen.sv */
`timescale 1ns/100ps

module flowAddrGen
(
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     run,
   input  versatPkg::addrGenConfigT cfg,
   output versatPkg::memAddrT       addr,
   output logic                     en,
   output logic                     done
);

   versatPkg::genStateT state;
   versatPkg::periodT   delayCnt;
   versatPkg::periodT   step;
   versatPkg::memAddrT  iter;
   versatPkg::memAddrT  base;
   versatPkg::periodT   nextStep;
   versatPkg::memAddrT  nextBase;
   logic                periodEnd;
   logic                lastIter;
   logic                noWork;

   assign nextStep  = step + 1'b1;
   assign nextBase  = base + cfg.shift;
   assign periodEnd = step == versatPkg::periodT'(cfg.period - 1'b1);
   assign lastIter  = iter == versatPkg::memAddrT'(cfg.iterations - 1'b1);

   // zero iterations finishes without waiting out the delay
   assign noWork    = cfg.iterations == '0 || cfg.period == '0;

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         state    <= versatPkg::GEN_IDLE;
         delayCnt <= '0;
         step     <= '0;
         iter     <= '0;
         base     <= '0;
         addr     <= '0;
         en       <= 1'b0;
         done     <= 1'b1;
      end
      else
      begin
         case (state)
            versatPkg::GEN_IDLE:
               if (run)
               begin
                  state    <= versatPkg::GEN_DELAY;
                  delayCnt <= cfg.delay;
                  done     <= 1'b0;
               end
            versatPkg::GEN_DELAY:
               if (noWork)
               begin
                  state <= versatPkg::GEN_IDLE;
                  done  <= 1'b1;
               end
               else if (delayCnt != '0)
                  delayCnt <= delayCnt - 1'b1;
               else
               begin
                  // present step 0 of the first period
                  state <= versatPkg::GEN_RUN;
                  step  <= '0;
                  iter  <= '0;
                  base  <= cfg.start;
                  addr  <= cfg.start;
                  en    <= cfg.duty != '0;
               end
            versatPkg::GEN_RUN:
               if (periodEnd && lastIter)
               begin
                  state <= versatPkg::GEN_IDLE;
                  en    <= 1'b0;
                  done  <= 1'b1;
               end
               else if (periodEnd)
               begin
                  step <= '0;
                  iter <= iter + 1'b1;
                  base <= nextBase;
                  addr <= nextBase;
                  en   <= cfg.duty != '0;
               end
               else
               begin
                  step <= nextStep;
                  addr <= addr + cfg.incr;
                  en   <= nextStep < cfg.duty;
               end
            default:
               state <= versatPkg::GEN_IDLE;
         endcase
      end
   end

   enOnlyInRun: assert property (@(posedge clk) disable iff (!rstN)
      en |-> state == versatPkg::GEN_RUN && !done);

endmodule

/* hw/flowWriter.sv */
`timescale 1ns/100ps

module flowWriter
(
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  run,
   input  versatPkg::flowBusT    flowIn,
   input  versatPkg::flowConfigT cfg,
   output versatPkg::memWriteT   memWrite,
   output logic                  done
);

   logic [versatPkg::N_FLOW-1:0][versatPkg::DATA_W-1:0] lanes;
   versatPkg::memAddrT genAddr;
   logic               genEn;

   function automatic versatPkg::memAddrT mirror(input versatPkg::memAddrT a);
      versatPkg::memAddrT r;
      for (int i = 0; i < versatPkg::MEM_ADDR_W; i++)
         r[i] = a[versatPkg::MEM_ADDR_W-1-i];
      return r;
   endfunction

   flowAddrGen gen
   (
      .clk  (clk),
      .rstN (rstN),
      .run  (run),
      .cfg  (cfg.gen),
      .addr (genAddr),
      .en   (genEn),
      .done (done)
   );

   assign lanes = flowIn;

   // lane data is taken in the same cycle the address is presented
   always_comb
   begin
      memWrite.en   = genEn;
      memWrite.addr = cfg.reverse ? mirror(genAddr) : genAddr;
      memWrite.data = lanes[cfg.sel];
   end

endmodule

/* hw/stageMem.sv */
`timescale 1ns/100ps

module stageMem
(
   input  logic                 clk,
   input  versatPkg::memWriteT  memWrite,
   input  versatPkg::memReadT   memRead,
   output versatPkg::dataT      readData
);

   versatPkg::dataT mem [2**versatPkg::MEM_ADDR_W];

   always_ff @(posedge clk)
   begin
      if (memWrite.en)
         mem[memWrite.addr] <= memWrite.data;
   end

   // read data holds between reads
   always_ff @(posedge clk)
   begin
      if (memRead.en)
         readData <= mem[memRead.addr];
   end

endmodule

/* hw/vWrite.sv */
`timescale 1ns/100ps

module vWrite
(
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  run,
   input  versatPkg::flowBusT    flowIn,
   input  versatPkg::flowConfigT flowConfig,
   input  versatPkg::extConfigT  extConfig,
   input  logic                  busReady,
   output versatPkg::busReqT     busReq,
   output logic                  doneA,
   output logic                  doneB
);

   versatPkg::memWriteT memWrite;
   versatPkg::memReadT  memRead;
   versatPkg::dataT     readData;

   // fill side writes flow lanes into the staging memory
   flowWriter fill
   (
      .clk      (clk),
      .rstN     (rstN),
      .run      (run),
      .flowIn   (flowIn),
      .cfg      (flowConfig),
      .memWrite (memWrite),
      .done     (doneB)
   );

   stageMem mem
   (
      .clk      (clk),
      .memWrite (memWrite),
      .memRead  (memRead),
      .readData (readData)
   );

   // drain side sends the previous run's words to the bus
   extWriteEngine drain
   (
      .clk      (clk),
      .rstN     (rstN),
      .run      (run),
      .cfg      (extConfig),
      .memRead  (memRead),
      .readData (readData),
      .busReady (busReady),
      .busReq   (busReq),
      .done     (doneA)
   );

endmodule

/* hw/versatPkg.sv */
package versatPkg;

   localparam int DATA_W         = 32;
   localparam int MEM_ADDR_W     = 8;
   localparam int IO_ADDR_W      = 32;
   localparam int IO_SIZE_W      = 9;
   localparam int PERIOD_W       = 6;
   localparam int N_FLOW         = 4;
   localparam int SEL_W          = 2;
   localparam int BYTES_PER_WORD = 4;

   typedef logic [DATA_W-1:0]        dataT;
   typedef logic [MEM_ADDR_W-1:0]    memAddrT;
   typedef logic [IO_ADDR_W-1:0]     ioAddrT;
   typedef logic [IO_SIZE_W-1:0]     ioSizeT;
   typedef logic [PERIOD_W-1:0]      periodT;
   typedef logic [SEL_W-1:0]         flowSelT;

   // lane 0 sits in the low word
   typedef logic [N_FLOW*DATA_W-1:0] flowBusT;

   // single loop level generator settings
   typedef struct packed
   {
      memAddrT iterations;
      periodT  period;
      periodT  duty;
      periodT  delay;
      memAddrT start;
      memAddrT shift;
      memAddrT incr;
   } addrGenConfigT;

   typedef struct packed
   {
      addrGenConfigT gen;
      flowSelT       sel;
      logic          reverse;
   } flowConfigT;

   // drain side settings
   typedef struct packed
   {
      ioAddrT  extAddr;
      memAddrT intAddr;
      ioSizeT  size;
   } extConfigT;

   typedef struct packed
   {
      logic    en;
      memAddrT addr;
      dataT    data;
   } memWriteT;

   typedef struct packed
   {
      logic    en;
      memAddrT addr;
   } memReadT;

   typedef struct packed
   {
      logic   valid;
      ioAddrT addr;
      dataT   wdata;
   } busReqT;

   typedef enum logic [1:0]
   {
      GEN_IDLE,
      GEN_DELAY,
      GEN_RUN
   } genStateT;

   typedef enum logic [1:0]
   {
      EXT_IDLE,
      EXT_READ,
      EXT_WAIT
   } extStateT;

endpackage

/* verification/vWriteTb.sv */
`timescale 1ns/100ps

module vWriteTb;

   localparam int RESET_CYCLES = 16;
   localparam int RESET_LEN    = 10;
   localparam int LINEAR_LEN   = 80;
   localparam int PATTERN_LEN  = 340;
   localparam int REVERSE_LEN  = 80;
   localparam int STALL_LEN    = 220;
   localparam int CYCLE_LIMIT  =
      2 * (RESET_LEN + LINEAR_LEN + PATTERN_LEN + REVERSE_LEN + STALL_LEN) + RESET_CYCLES;

   logic                  clk;
   logic                  rstN;
   logic                  run;
   versatPkg::flowBusT    flowIn = '0;
   versatPkg::flowConfigT flowConfig;
   versatPkg::extConfigT  extConfig;
   logic                  busReady = 1'b1;
   versatPkg::busReqT     busReq;
   logic                  doneA;
   logic                  doneB;

   int          cycle = 0;
   int          errors = 0;
   int          testErrors = 0;
   int          testsRun = 0;
   string       testName = "";
   logic [31:0] rngState = 32'd38;
   logic        randomReady = 1'b0;

   versatPkg::dataT model [256];
   logic            written [256];

   vWrite uut
   (
      .clk        (clk),
      .rstN       (rstN),
      .run        (run),
      .flowIn     (flowIn),
      .flowConfig (flowConfig),
      .extConfig  (extConfig),
      .busReady   (busReady),
      .busReq     (busReq),
      .doneA      (doneA),
      .doneB      (doneB)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // lane number in the top byte and edge index below
   function automatic versatPkg::dataT laneWord(input int lane, input int c);
      return {lane[7:0], c[23:0]};
   endfunction

   function automatic versatPkg::flowBusT makeFlow(input int c);
      versatPkg::flowBusT f;
      for (int lane = 0; lane < versatPkg::N_FLOW; lane++)
         f[lane*versatPkg::DATA_W +: versatPkg::DATA_W] = laneWord(lane, c);
      return f;
   endfunction

   function automatic versatPkg::memAddrT mirrorBits(input versatPkg::memAddrT a);
      versatPkg::memAddrT r;
      for (int i = 0; i < versatPkg::MEM_ADDR_W; i++)
         r[versatPkg::MEM_ADDR_W-1-i] = a[i];
      return r;
   endfunction

   // flow word driven at edge e carries e and ready is random or high
   always @(posedge clk)
   begin
      logic [31:0] nextState;
      nextState = xorshift(rngState);
      cycle  <= cycle + 1;
      flowIn <= makeFlow(cycle + 1);
      if (randomReady)
      begin
         rngState <= nextState;
         busReady <= nextState[7];
      end
      else
         busReady <= 1'b1;
   end

   always @(posedge clk)
   begin
      if (cycle >= CYCLE_LIMIT)
      begin
         $display("timeout: simulation still running after %0d cycles", CYCLE_LIMIT);
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic countError();
      errors++;
      testErrors++;
   endtask

   task automatic compareData(input string what, input versatPkg::dataT expected,
                              input versatPkg::dataT actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s: %s expected %h, actual %h", testName, what, expected, actual);
         countError();
      end
   endtask

   task automatic compareAddr(input string what, input versatPkg::ioAddrT expected,
                              input versatPkg::ioAddrT actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s: %s expected %h, actual %h", testName, what, expected, actual);
         countError();
      end
   endtask

   task automatic compareBit(input string what, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s: %s expected %b, actual %b", testName, what, expected, actual);
         countError();
      end
   endtask

   task automatic beginTest(input string name);
      testName   = name;
      testErrors = 0;
   endtask

   task automatic endTest();
      testsRun++;
      $display("%s: %s, %0d errors", testName, testErrors == 0 ? "ok" : "failed", testErrors);
   endtask

   // step n shows up in the cycle after edge runEdge+1+delay+n
   function automatic void predictFill(input versatPkg::flowConfigT cfg, input int runEdge);
      versatPkg::memAddrT base;
      versatPkg::memAddrT a;
      int                 firstStep;
      firstStep = runEdge + 1 + int'(cfg.gen.delay);
      base = cfg.gen.start;
      for (int it = 0; it < int'(cfg.gen.iterations); it++)
      begin
         for (int j = 0; j < int'(cfg.gen.period); j++)
         begin
            a = versatPkg::memAddrT'(int'(base) + j * int'(cfg.gen.incr));
            if (cfg.reverse)
               a = mirrorBits(a);
            if (j < int'(cfg.gen.duty))
            begin
               model[a]   = laneWord(int'(cfg.sel), firstStep + it * int'(cfg.gen.period) + j);
               written[a] = 1'b1;
            end
         end
         base = base + cfg.gen.shift;
      end
   endfunction

   task automatic pulseRun(output int runEdge);
      run <= 1'b1;
      @(posedge clk);
      // index of the edge that samples run
      runEdge = cycle + 1;
      run <= 1'b0;
   endtask

   task automatic waitIdle();
      while (!(doneA && doneB))
         @(posedge clk);
   endtask

   task automatic runFill(input versatPkg::flowConfigT cfg);
      versatPkg::extConfigT noDrain;
      int                   runEdge;
      int                   expectRise;
      noDrain = '0;
      flowConfig <= cfg;
      extConfig  <= noDrain;
      pulseRun(runEdge);
      predictFill(cfg, runEdge);
      expectRise = runEdge + 1 + int'(cfg.gen.delay)
                   + int'(cfg.gen.iterations) * int'(cfg.gen.period);
      @(posedge clk);
      compareBit("doneB after run", 1'b0, doneB);
      while (!doneB)
      begin
         compareBit("doneA during fill", 1'b1, doneA);
         @(posedge clk);
      end
      // doneB seen high now, so it rose at the previous edge
      if (cycle != expectRise)
      begin
         $display("CHECK FAILED %s: doneB rise edge expected %0d, actual %0d",
                  testName, expectRise, cycle);
         countError();
      end
      waitIdle();
   endtask

   task automatic runDrain(input versatPkg::extConfigT cfg);
      versatPkg::flowConfigT idleFill;
      versatPkg::busReqT     held;
      versatPkg::memAddrT    intAddr;
      versatPkg::ioAddrT     expAddr;
      int                    runEdge;
      int                    sent;
      logic                  stalled;
      idleFill = '0;
      held     = '0;
      sent     = 0;
      stalled  = 1'b0;
      flowConfig <= idleFill;
      extConfig  <= cfg;
      pulseRun(runEdge);
      while (sent < int'(cfg.size))
      begin
         @(posedge clk);
         if (stalled)
         begin
            compareBit("valid under stall", 1'b1, busReq.valid);
            compareAddr("addr under stall", held.addr, busReq.addr);
            compareData("wdata under stall", held.wdata, busReq.wdata);
         end
         compareBit("doneA during drain", 1'b0, doneA);
         // first word is up one cycle after the edge that takes run
         if (cycle == runEdge + 1)
            compareBit("valid after run", 1'b1, busReq.valid);
         if (busReq.valid && busReady)
         begin
            intAddr = versatPkg::memAddrT'(int'(cfg.intAddr) + sent);
            expAddr = cfg.extAddr + versatPkg::ioAddrT'(versatPkg::BYTES_PER_WORD * sent);
            compareAddr("bus addr", expAddr, busReq.addr);
            if (written[intAddr])
               compareData("bus wdata", model[intAddr], busReq.wdata);
            sent++;
         end
         stalled = busReq.valid && !busReady;
         held    = busReq;
      end
      @(posedge clk);
      compareBit("doneA after last word", 1'b1, doneA);
      compareBit("valid after last word", 1'b0, busReq.valid);
      waitIdle();
   endtask

   task automatic checkReset();
      beginTest("reset state");
      @(posedge clk);
      compareBit("doneA", 1'b1, doneA);
      compareBit("doneB", 1'b1, doneB);
      compareBit("busReq.valid", 1'b0, busReq.valid);
      compareBit("memWrite.en", 1'b0, uut.memWrite.en);
      endTest();
   endtask

   task automatic checkLinear();
      versatPkg::flowConfigT fc;
      versatPkg::extConfigT  ec;
      beginTest("linear fill and drain");
      fc = '0;
      fc.gen.iterations = 8'd16;
      fc.gen.period     = 6'd1;
      fc.gen.duty       = 6'd1;
      fc.gen.incr       = 8'd1;
      fc.gen.shift      = 8'd1;
      fc.sel            = 2'd2;
      runFill(fc);
      ec = '0;
      ec.extAddr = 32'h1000;
      ec.size    = 9'd16;
      runDrain(ec);
      endTest();
   endtask

   task automatic checkPattern();
      versatPkg::flowConfigT fc;
      versatPkg::extConfigT  ec;
      beginTest("duty shift incr pattern");
      fc = '0;
      fc.gen.iterations = 8'd8;
      fc.gen.period     = 6'd4;
      fc.gen.duty       = 6'd2;
      fc.gen.delay      = 6'd3;
      fc.gen.start      = 8'd5;
      fc.gen.shift      = 8'd16;
      fc.gen.incr       = 8'd3;
      fc.sel            = 2'd0;
      runFill(fc);
      ec = '0;
      ec.extAddr = 32'h2000;
      ec.size    = 9'd128;
      runDrain(ec);
      endTest();
   endtask

   // bases 0,16..240 mirror onto words 0..15
   task automatic checkReverse();
      versatPkg::flowConfigT fc;
      versatPkg::extConfigT  ec;
      beginTest("bit reversed fill");
      fc = '0;
      fc.gen.iterations = 8'd16;
      fc.gen.period     = 6'd1;
      fc.gen.duty       = 6'd1;
      fc.gen.shift      = 8'd16;
      fc.sel            = 2'd1;
      fc.reverse        = 1'b1;
      runFill(fc);
      ec = '0;
      ec.extAddr = 32'h3000;
      ec.size    = 9'd16;
      runDrain(ec);
      endTest();
   endtask

   task automatic checkBackPressure();
      versatPkg::flowConfigT fc;
      versatPkg::extConfigT  ec;
      beginTest("back-pressure");
      fc = '0;
      fc.gen.iterations = 8'd32;
      fc.gen.period     = 6'd1;
      fc.gen.duty       = 6'd1;
      fc.gen.shift      = 8'd1;
      fc.sel            = 2'd3;
      runFill(fc);
      randomReady <= 1'b1;
      ec = '0;
      ec.extAddr = 32'h4000;
      ec.size    = 9'd32;
      runDrain(ec);
      randomReady <= 1'b0;
      @(posedge clk);
      endTest();
   endtask

   initial
   begin
      rstN       = 1'b0;
      run        = 1'b0;
      flowConfig = '0;
      extConfig  = '0;
      for (int i = 0; i < 256; i++)
         written[i] = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rstN <= 1'b1;
      @(posedge clk);
      checkReset();
      checkLinear();
      checkPattern();
      checkReverse();
      checkBackPressure();
      $display("tests run %0d, errors %0d", testsRun, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

/* verilog.f */
hw/versatPkg.sv
hw/flowAddrGen.sv
hw/flowWriter.sv
hw/stageMem.sv
hw/extWriteEngine.sv
hw/vWrite.sv
verification/vWriteTb.sv
